//--- verilog.f
source/obj_pkg.sv
source/obj_attr_decode.sv
source/obj_rom_addr.sv
source/obj_pixel_shift.sv
source/obj_palette.sv
source/obj_draw_top.sv
dv/obj_rom_model.sv
dv/obj_draw_tb.sv

//--- Bender.yml
package:
  name: obj_draw

sources:
  - files:
      - source/obj_pkg.sv
      - source/obj_attr_decode.sv
      - source/obj_rom_addr.sv
      - source/obj_pixel_shift.sv
      - source/obj_palette.sv
      - source/obj_draw_top.sv
  - target: simulation
    files:
      - dv/obj_rom_model.sv
      - dv/obj_draw_tb.sv

//--- dv/obj_draw_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Classic layout only, in-band objects placed on disjoint 32-pixel lanes
// Posx 0x1F0 and up is never checked, hidden objects park there
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module obj_draw_tb;

    localparam logic [8:0] XOUT = obj_pkg::XOUT_DEFAULT;
    localparam int NSLOT    = 12;
    localparam int PROM_WR  = 256 + 64;   // Full load plus the rewrite
    localparam int WATCHDOG = (NSLOT + 2) * 16 * 2 * 4 / 3 + PROM_WR + 500;

    logic                       clk = 1'b0;
    logic                       rst = 1'b1;
    logic                       cen = 1'b0;
    logic [7:0]                 vf = '0;
    logic                       flip = 1'b0;
    logic [3:0]                 pxlcnt = '0;
    logic [7:0]                 objbuf_data = '0;
    logic                       stall_req = 1'b0;
    logic                       draw_over = 1'b0;
    logic                       objon = 1'b1;
    logic [7:0]                 prog_addr = '0;
    logic [7:0]                 prog_din = '0;
    logic                       prog_we = 1'b0;
    logic                       rom_wait;
    logic [15:0]                obj_data;
    logic [obj_pkg::ROM_AW-1:0] obj_addr;
    obj_pkg::obj_out_t          pixel;

    logic [7:0]                 prom_ref [256];   // Mirror of the PROM
    logic [7:0]                 exp_idx [512];    // PROM index per posx
    logic                       exp_valid [512];
    logic [obj_pkg::ROM_AW-1:0] slot_addr [4];    // Fetch address per column
    logic [obj_pkg::ROM_AW-1:0] exp_addr = '0;
    logic                       fetch_chk = 1'b0;
    logic                       running = 1'b0;   // Slots started
    logic [7:0]                 dov_idx = '0;     // {pal, 4'hF} of the last slot
    logic [31:0]                rng = 32'd40051;
    int                         err_cnt = 0;
    logic                       chk_hit;
    logic [7:0]                 chk_col;
    logic [7:0]                 dov_col;
    logic                       dov_ok;

    always #5 clk = ~clk;

    obj_draw_top #(.layout(0), .xout(XOUT)) uut (
        .clk(clk), .rst(rst), .cen(cen), .vf(vf), .flip(flip), .pxlcnt(pxlcnt),
        .objbuf_data(objbuf_data), .obj_addr(obj_addr), .obj_data(obj_data),
        .rom_wait(rom_wait), .draw_over(draw_over), .objon(objon),
        .prog_addr(prog_addr), .prog_din(prog_din), .prog_we(prog_we), .pixel(pixel)
    );

    obj_rom_model u_rom (.stall(stall_req), .addr(obj_addr), .data(obj_data), .rom_wait(rom_wait));

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Same hash the ROM model answers with
    function automatic logic [15:0] rom_word(input logic [obj_pkg::ROM_AW-1:0] a);
        logic [31:0] h;
        h = xorshift(32'h9E3779B9 ^ 32'(a));
        return h[15:0] ^ h[31:16];
    endfunction

    task automatic fail_now(input string what);
        err_cnt++;
        $display("[ERROR] %0t ns: %s", $time, what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // PROM write while the pipeline is stalled
    task automatic prom_write(input logic [7:0] a, input logic [7:0] d);
        cen       = 1'b1;
        stall_req = 1'b1;
        prog_addr = a;
        prog_din  = d;
        prog_we   = 1'b1;
        @(posedge clk);
        #1;
        prom_ref[a] = d;
        prog_we     = 1'b0;
    endtask

    // One pxlcnt step, repeated over idle and wait cycles until it is taken
    task automatic do_step(input logic [3:0] k, input logic [7:0] ob);
        logic [31:0] r;
        logic        done;
        done        = 1'b0;
        pxlcnt      = k;
        objbuf_data = ob;
        exp_addr    = slot_addr[k[3:2]];
        while (!done) begin
            r         = next_rand();
            cen       = r[5:4] != 2'd0;    // High on 3 of 4
            stall_req = r[10:8] == 3'd0;
            fetch_chk = cen && !stall_req && (k[1:0] == 2'd3);
            @(posedge clk);
            #1;
            done = cen && !stall_req;
        end
        fetch_chk = 1'b0;
    endtask

    // Random object, reference fill, then its 16 steps
    task automatic run_slot(input int n, input logic hide);
        logic [31:0] r;
        logic [7:0]  code, attr, ypos, off, vadj;
        logic [8:0]  xpos;
        logic [3:0]  vline;
        logic [15:0] w;
        logic        inb;
        int          b;
        r       = next_rand();
        code    = r[7:0];
        attr    = r[15:8];
        vf      = r[23:16];
        flip    = r[24];
        xpos    = 9'(n * 32) + 9'(r[29:26]);  // Own lane per slot
        attr[0] = xpos[8];
        vadj    = flip ? 8'd0 - vf : 8'd0 - vf - 8'd2;
        r       = next_rand();
        off     = (r[0] && !hide) ? {4'hF, r[4:1]} : {1'b0, r[7:5], r[11:8]};
        ypos    = off - vadj;                 // Y giving the chosen offset
        inb     = &off[7:4];
        vline   = attr[3] ? off[3:0] : ~off[3:0];
        for (int c = 0; c < 4; c++) begin
            slot_addr[c] = '0;
            if (inb)
                slot_addr[c] = {1'b0, attr[7:6], code, vline, attr[2] ? 2'(3 - c) : 2'(c)};
        end
        for (int i = 0; i < 16 && inb; i++) begin
            w = rom_word(slot_addr[i / 4]);
            b = attr[2] ? i % 4 : 3 - i % 4;   // Bit order reverses under hflip
            exp_idx[xpos + i]   = {2'b00, attr[5:4], w[b], w[4 + b], w[8 + b], w[12 + b]};
            exp_valid[xpos + i] = 1'b1;
        end
        dov_idx = {2'b00, attr[5:4], 4'hF};
        for (int k = 0; k < 16; k++)
            do_step(4'(k), k == 0 ? code : k == 1 ? attr : k == 2 ? ypos :
                           k == 3 ? xpos[7:0] : 8'hA5);
    endtask

    assign chk_hit = running && exp_valid[pixel.posx];
    assign chk_col = prom_ref[exp_idx[pixel.posx]];
    assign dov_col = prom_ref[dov_idx];
    assign dov_ok  = draw_over && cen && !rom_wait;

    idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !running |-> obj_addr == '0 && pixel.colour == 8'h0F && pixel.posx == XOUT)
        else fail_now("output moved before the first slot");
    fetch_address: assert property (@(posedge clk) disable iff (rst)
        fetch_chk |=> obj_addr == $past(exp_addr))
        else fail_now("obj_addr differs from the expected fetch address");
    pixel_colour: assert property (@(posedge clk) disable iff (rst)
        chk_hit |-> pixel.colour == chk_col)
        else fail_now($sformatf("wrong colour %h at posx %h", pixel.colour, pixel.posx));
    hold_on_wait: assert property (@(posedge clk) disable iff (rst)
        (!cen || rom_wait) |=> obj_addr === $past(obj_addr) && pixel === $past(pixel))
        else fail_now("obj_addr or pixel changed during a stall");
    objon_blank: assert property (@(posedge clk) disable iff (rst)
        (cen && !rom_wait && !objon) |=> pixel.colour == 8'h0F && pixel.posx == XOUT)
        else fail_now("pixel not blanked with objon low");
    draw_over_fill: assert property (@(posedge clk) disable iff (rst)
        dov_ok && $past(dov_ok) && $past(dov_ok, 2) |=>
            pixel.colour == dov_col && pixel.posx == XOUT)
        else fail_now("draw_over did not force colour 4'hF");

    initial begin
        for (int i = 0; i < 512; i++)
            exp_valid[i] = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int a = 0; a < 256; a++)
            prom_write(8'(a), 8'(255 - a));
        running = 1'b1;
        for (int n = 0; n < NSLOT; n++) begin
            // Slot 5 is hidden, so only off-screen pixels are in flight here
            if (n == 6) begin
                for (int a = 0; a < 64; a++)
                    prom_write(8'(a), 8'(a) ^ 8'h5A);
            end
            run_slot(n, n == 5);
        end
        run_slot(NSLOT, 1'b1);   // Flushes the last object
        objon = 1'b0;
        run_slot(NSLOT + 1, 1'b1);
        objon     = 1'b1;
        cen       = 1'b1;
        stall_req = 1'b0;
        draw_over = 1'b1;
        repeat (6) begin
            @(posedge clk);
            #1;
        end
        draw_over = 1'b0;
        repeat (3) @(posedge clk);
        if (err_cnt == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        #(WATCHDOG * 10);
        $display("timeout: the object stream did not finish within %0d cycles", WATCHDOG);
        $display("ERRORS FOUND");
        $fatal(1);
    end

endmodule

//--- dv/obj_rom_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational graphics ROM, each word is an xorshift hash of its address
// rom_wait simply follows the stall request from the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module obj_rom_model #(
    parameter int AW = obj_pkg::ROM_AW
) (
    input  logic          stall,     // Wait state request from the test
    input  logic [AW-1:0] addr,
    output logic [15:0]   data,
    output logic          rom_wait
);

    // Seeded so that address 0 still gives a busy word
    function automatic logic [15:0] hash_word(input logic [AW-1:0] a);
        logic [31:0] s;
        s = 32'h9E3779B9 ^ 32'(a);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s[15:0] ^ s[31:16];  // Fold both halves
    endfunction

    assign data     = hash_word(addr);
    assign rom_wait = stall;

endmodule

//--- source/obj_draw_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Object draw pipeline, attribute to palette
// Expects an external 16-step pxlcnt per slot and an object buffer
// presenting code, attribute, Y and X on steps 0 to 3
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module obj_draw_top #(
    parameter int unsigned layout = 0,  // 0 classic, 1 extended
    parameter logic [8:0]  xout   = obj_pkg::XOUT_DEFAULT
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    // Screen timing
    input  logic [7:0]                 vf,
    input  logic                       flip,
    input  logic [3:0]                 pxlcnt,
    // Object buffer
    input  logic [7:0]                 objbuf_data,
    // Graphics ROM
    output logic [obj_pkg::ROM_AW-1:0] obj_addr,
    input  logic [15:0]                obj_data,
    input  logic                       rom_wait,
    input  logic                       draw_over,
    input  logic                       objon,
    // PROM load port
    input  logic [7:0]                 prog_addr,
    input  logic [7:0]                 prog_din,
    input  logic                       prog_we,
    output obj_pkg::obj_out_t          pixel
);

    obj_pkg::obj_desc_t desc;  // Current object record
    obj_pkg::obj_pxl_t  raw;   // Unpacked pixel

    obj_attr_decode #(
        .layout ( layout ),
        .xout   ( xout   )
    ) u_attr (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .cen         ( cen         ),
        .rom_wait    ( rom_wait    ),
        .pxlcnt      ( pxlcnt      ),
        .vf          ( vf          ),
        .flip        ( flip        ),
        .objbuf_data ( objbuf_data ),
        .desc        ( desc        )
    );

    obj_rom_addr u_addr (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( cen      ),
        .rom_wait ( rom_wait ),
        .pxlcnt   ( pxlcnt   ),
        .desc     ( desc     ),
        .obj_addr ( obj_addr )
    );

    obj_pixel_shift #(.xout(xout)) u_shift (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cen       ( cen       ),
        .rom_wait  ( rom_wait  ),
        .draw_over ( draw_over ),
        .pxlcnt    ( pxlcnt    ),
        .desc      ( desc      ),
        .obj_data  ( obj_data  ),
        .raw       ( raw       )
    );

    obj_palette #(.xout(xout)) u_pal (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cen       ( cen       ),
        .rom_wait  ( rom_wait  ),
        .objon     ( objon     ),
        .raw       ( raw       ),
        .prog_addr ( prog_addr ),
        .prog_din  ( prog_din  ),
        .prog_we   ( prog_we   ),
        .pixel     ( pixel     )
    );

endmodule

//--- source/obj_palette.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 256x8 colour PROM, writable on any enabled cycle, contents not reset
// Two enabled non-stalled cycles from raw to pixel
// objon low sends colour 8'h0F to XOUT
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module obj_palette #(
    parameter logic [8:0] xout = obj_pkg::XOUT_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              rom_wait,
    input  logic              objon,
    input  obj_pkg::obj_pxl_t raw,
    input  logic [7:0]        prog_addr,
    input  logic [7:0]        prog_din,
    input  logic              prog_we,
    output obj_pkg::obj_out_t pixel
);

    logic [7:0] prom [256];
    logic [7:0] prom_q;   // Colour one cycle after the raw pixel
    logic [7:0] rd_addr;
    logic [8:0] posx_d;   // posx aligned with prom_q
    logic       adv;

    assign rd_addr = {raw.pal, raw.col};
    assign adv     = cen & ~rom_wait;

    // Write port ignores the stall so loading never waits on the ROM
    always_ff @(posedge clk) begin
        if (cen) begin
            if (prog_we)
                prom[prog_addr] <= prog_din;
            if (!rom_wait)
                prom_q <= prom[rd_addr];  // Old data on a same-address write
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            posx_d       <= xout;
            pixel.colour <= 8'h0F;
            pixel.posx   <= xout;
        end else if (adv) begin
            posx_d <= raw.posx;
            if (objon) begin
                pixel.colour <= prom_q;
                pixel.posx   <= posx_d;
            end else begin
                // Objects layer off
                pixel.colour <= 8'h0F;
                pixel.posx   <= xout;
            end
        end
    end

endmodule

//--- source/obj_pixel_shift.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Unpacks each ROM word into four 4-bit planes, one pixel per step
// Slot data latches at pxlcnt 7 and planes reload every fourth step
// draw_over blanks the stage but still holds during a stall
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module obj_pixel_shift #(
    parameter logic [8:0] xout = obj_pkg::XOUT_DEFAULT
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               rom_wait,
    input  logic               draw_over,
    input  logic [3:0]         pxlcnt,
    input  obj_pkg::obj_desc_t desc,
    input  logic [15:0]        obj_data,
    output obj_pkg::obj_pxl_t  raw
);

    logic [3:0]                pl_w;   // Plane 0 from word bits 3:0
    logic [3:0]                pl_x;
    logic [3:0]                pl_y;
    logic [3:0]                pl_z;   // Plane 3 from word bits 15:12
    logic [obj_pkg::PAL_W-1:0] pal_l;  // Palette of the slot on screen
    logic                      hflip_l;
    logic [8:0]                posx;   // Line buffer position

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {pl_z, pl_y, pl_x, pl_w} <= 16'hFFFF;
            pal_l   <= '0;
            hflip_l <= 1'b0;
            posx    <= xout;
        end else if (cen && !rom_wait) begin
            if (draw_over) begin
                // Line done so flush with transparent colour
                {pl_z, pl_y, pl_x, pl_w} <= 16'hFFFF;
                posx <= xout;
            end else begin
                if (pxlcnt == 4'd7) begin
                    pal_l   <= desc.pal;
                    hflip_l <= desc.hflip;
                    posx    <= desc.x;     // First pixel of the new object
                end else begin
                    posx    <= posx + 9'd1;
                end

                if (pxlcnt[1:0] == 2'd3) begin
                    {pl_z, pl_y, pl_x, pl_w} <= obj_data; // New column word
                end else if (hflip_l) begin
                    pl_w <= pl_w >> 1;
                    pl_x <= pl_x >> 1;
                    pl_y <= pl_y >> 1;
                    pl_z <= pl_z >> 1;
                end else begin
                    pl_w <= pl_w << 1;
                    pl_x <= pl_x << 1;
                    pl_y <= pl_y << 1;
                    pl_z <= pl_z << 1;
                end
            end
        end
    end

    // Pixel leaves from the end the planes shift towards
    assign raw.col  = hflip_l ? {pl_w[0], pl_x[0], pl_y[0], pl_z[0]}
                              : {pl_w[3], pl_x[3], pl_y[3], pl_z[3]};
    assign raw.pal  = pal_l;
    assign raw.posx = posx;

endmodule

//--- source/obj_rom_addr.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch address loads at pxlcnt 3, 7, 11 and 15 of each slot
// ROM data is expected four enabled steps later
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module obj_rom_addr (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    input  logic                       rom_wait,
    input  logic [3:0]                 pxlcnt,
    input  obj_pkg::obj_desc_t         desc,
    output logic [obj_pkg::ROM_AW-1:0] obj_addr
);

    logic [1:0] col;    // Column within the 16-pixel object
    logic       fetch;  // Last step of each 4-step group

    // Mirrored objects read columns right to left
    assign col   = pxlcnt[3:2] ^ {2{desc.hflip}};
    assign fetch = pxlcnt[1:0] == 2'd3;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            obj_addr <= '0;
        end else if (cen && !rom_wait && fetch) begin
            if (desc.inzone)
                obj_addr <= {desc.id, desc.vline, col};
            else
                obj_addr <= '0;  // Idle address for hidden objects
        end
    end

endmodule

//--- source/obj_attr_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Attribute words must sit on objbuf_data at pxlcnt 0..3 of each slot
// desc fields update one step at a time, full record valid from step 4
// layout 0 is classic, any other value selects the extended decode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module obj_attr_decode #(
    parameter int unsigned layout = 0,
    parameter logic [8:0]  xout   = obj_pkg::XOUT_DEFAULT
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               rom_wait,
    input  logic [3:0]         pxlcnt,
    input  logic [7:0]         vf,
    input  logic               flip,
    input  logic [7:0]         objbuf_data,
    output obj_pkg::obj_desc_t desc
);

    obj_pkg::obj_attr_u attr;   // Step 1 byte, two views
    logic [7:0]         vsum;   // Line offset inside the object band
    logic               xhi;    // X bit 8, held until step 3
    logic               adv;    // Stage may advance

    assign attr = objbuf_data;
    assign adv  = cen & ~rom_wait;

    // Negated line plus object Y
    // flip shifts the offset by one so flipped screens line up
    always_comb begin
        vsum = (~vf + {{7{~flip}}, 1'b1}) + objbuf_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            desc   <= '0;
            desc.x <= xout;  // Nothing visible before the first slot
            xhi    <= 1'b0;
        end else if (adv) begin
            case (pxlcnt)
                4'd0: desc.id[7:0] <= objbuf_data; // Code low byte
                4'd1: begin
                    if (layout == 0) begin
                        desc.id[10:8] <= {1'b0, attr.classic.id_hi};
                        desc.pal      <= {2'b00, attr.classic.pal};
                        desc.vflip    <= attr.classic.vflip;
                        desc.hflip    <= attr.classic.hflip;
                        xhi           <= attr.classic.xhi;
                    end else begin
                        // Extended board has no flip wiring
                        desc.id[10:8] <= attr.extended.id_hi;
                        desc.pal      <= attr.extended.pal;
                        desc.vflip    <= 1'b0;
                        desc.hflip    <= 1'b0;
                        xhi           <= attr.extended.xhi;
                    end
                end
                4'd2: begin
                    // ROM stores lines bottom up unless vflip
                    desc.vline  <= vsum[3:0] ^ {4{~desc.vflip}};
                    desc.inzone <= &vsum[7:4]; // Top nibble all ones
                end
                4'd3: begin
                    // Park out-of-band objects off screen
                    desc.x <= desc.inzone ? {xhi, objbuf_data} : xout;
                end
                default: ;  // Steps 4..15 hold the record
            endcase
        end
    end

endmodule

//--- source/obj_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths and stage records for the object draw pipeline
// The classic layout leaves id[10] at zero and uses only pal[1:0]
// The ROM address is {id, vline, column}, so ROM_AW follows ID_W
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package obj_pkg;

    localparam int ID_W   = 11;           // Object code width
    localparam int ROM_AW = ID_W + 4 + 2; // Code, line in tile, fetch column
    localparam int PAL_W  = 4;            // Palette field, widest layout

    // Off-screen X in the line buffer
    localparam logic [8:0] XOUT_DEFAULT = 9'h1F0;

    // Attribute byte as read in the classic layout
    typedef struct packed {
        logic [1:0] id_hi;  // Code bits 9:8
        logic [1:0] pal;
        logic       vflip;
        logic       hflip;
        logic       unused; // Not wired on the board
        logic       xhi;    // X bit 8
    } obj_attr_classic_t;

    // Same byte in the extended layout, no flip bits
    typedef struct packed {
        logic [2:0] id_hi;  // Code bits 10:8
        logic       xhi;
        logic [3:0] pal;
    } obj_attr_ext_t;

    // One attribute byte, two decodes picked by the layout parameter
    typedef union packed {
        obj_attr_classic_t classic;
        obj_attr_ext_t     extended;
    } obj_attr_u;

    // Decoded object, from attribute stage to address and depack stages
    typedef struct packed {
        logic [ID_W-1:0]  id;
        logic [PAL_W-1:0] pal;
        logic             vflip;
        logic             hflip;
        logic [3:0]       vline;   // Line within the tile, ROM order
        logic             inzone;  // Current line hits the object band
        logic [8:0]       x;       // Start X, XOUT when out of band
    } obj_desc_t;

    // Raw pixel before the colour PROM
    typedef struct packed {
        logic [PAL_W-1:0] pal;
        logic [3:0]       col;     // Planes w, x, y, z
        logic [8:0]       posx;
    } obj_pxl_t;

    // Final pixel towards the line buffer
    typedef struct packed {
        logic [7:0] colour;
        logic [8:0] posx;
    } obj_out_t;

endpackage
